//--- source/fetch_pkg.sv
////////////////////////////////////////
// Shared widths and instruction decoding for the fetch front end.
// Only RV32 word-sized instructions are handled; no compressed forms.
// inst_word_t overlays the generic R-style fields and the J-type
// immediate fields on the same 32-bit word.
////////////////////////////////////////
package fetch_pkg;

	parameter int addr_w = 32;
	parameter int data_w = 32;

	parameter logic [6:0] op_jal = 7'b1101111;

	typedef union packed {
		// register and function fields
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} gen;
		// jal immediate layout
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_word_t;

endpackage

//--- source/mem_rd_if.sv
////////////////////////////////////////
// AXI-Lite style read bus, address and data channels only.
// One outstanding transaction per requester.
////////////////////////////////////////
`timescale 1ns/1ps

interface mem_rd_if;

	logic [fetch_pkg::addr_w-1:0] araddr;
	logic                         arvalid;
	logic                         arready;
	logic                         rvalid;
	logic                         rready;
	logic [fetch_pkg::data_w-1:0] rdata;

	modport requester (
		output araddr, arvalid, rready,
		input  arready, rvalid, rdata
	);

	modport arbiter (
		input  araddr, arvalid, rready,
		output arready, rvalid, rdata
	);

endinterface

//--- source/fetch_unit.sv
////////////////////////////////////////
// Instruction fetch with one read in flight.
// A fetched word is held until decode takes it; no new read starts
// while a word is held. JAL targets are predicted from the held word.
// redirect and exc bump a 2-bit epoch; stale responses are dropped.
////////////////////////////////////////
`timescale 1ns/1ps

module fetch_unit #(
	parameter logic [fetch_pkg::addr_w-1:0] reset_pc = 32'h8000_0000
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         inst_ready,
	input  logic                         redirect,
	input  logic                         exc,
	input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
	input  logic [fetch_pkg::addr_w-1:0] trap_vector,
	output logic                         inst_valid,
	output fetch_pkg::inst_word_t        inst,
	output logic [fetch_pkg::addr_w-1:0] inst_pc,
	mem_rd_if.requester                  bus
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_data = 2'd2;

	logic [1:0]                   state;
	logic [fetch_pkg::addr_w-1:0] pc;
	logic [fetch_pkg::addr_w-1:0] pc_next;
	logic [fetch_pkg::addr_w-1:0] fetch_addr;
	logic [fetch_pkg::addr_w-1:0] jal_target;
	logic [1:0]                   cur_epoch;
	logic [1:0]                   epoch_next;
	logic [1:0]                   req_epoch;
	logic                         flush;
	logic                         take;
	logic                         can_issue;
	logic                         is_jal;

	assign flush = redirect | exc;
	assign take = inst_valid & inst_ready;
	// a flush drops the held word, so a new read may start at once
	assign can_issue = ~inst_valid | take | flush;
	assign epoch_next = cur_epoch + {1'b0, flush};

	assign is_jal = (inst.gen.opcode == fetch_pkg::op_jal);
	assign jal_target = pc + {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
		inst.j.imm_11, inst.j.imm_10_1, 1'b0};

	// exc wins over redirect
	always_comb begin
		if (exc)
			pc_next = trap_vector;
		else if (redirect)
			pc_next = redirect_pc;
		else if (is_jal)
			pc_next = jal_target;
		else
			pc_next = pc + 32'd4;
	end

	assign fetch_addr = (take | flush) ? pc_next : pc;
	assign inst_pc = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			cur_epoch <= 2'd0;
		end else begin
			if (take | flush)
				pc <= pc_next;
			cur_epoch <= epoch_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			bus.arvalid <= 1'b0;
			bus.rready <= 1'b0;
			inst_valid <= 1'b0;
			req_epoch <= 2'd0;
		end else begin
			if (take | flush)
				inst_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (can_issue) begin
						bus.arvalid <= 1'b1;
						// epoch tag travels with the latched address
						req_epoch <= epoch_next;
						state <= st_addr;
					end
				end
				st_addr: begin
					if (bus.arready) begin
						bus.arvalid <= 1'b0;
						bus.rready <= 1'b1;
						state <= st_data;
					end
				end
				st_data: begin
					if (bus.rvalid) begin
						bus.rready <= 1'b0;
						state <= st_idle;
						if (req_epoch == cur_epoch && !flush)
							inst_valid <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && can_issue)
			bus.araddr <= fetch_addr;
		if (state == st_data && bus.rvalid)
			inst <= bus.rdata;
	end

endmodule

//--- source/load_port.sv
////////////////////////////////////////
// Single-word load requester, one load at a time.
// load_req is ignored while load_busy is high.
////////////////////////////////////////
`timescale 1ns/1ps

module load_port (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         load_req,
	input  logic [fetch_pkg::addr_w-1:0] load_addr,
	output logic                         load_busy,
	output logic                         load_done,
	output logic [fetch_pkg::data_w-1:0] load_data,
	mem_rd_if.requester                  bus
);

	logic accept;

	assign accept = load_req & ~load_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			load_busy <= 1'b0;
			load_done <= 1'b0;
			bus.arvalid <= 1'b0;
			bus.rready <= 1'b0;
		end else begin
			load_done <= 1'b0;
			if (accept) begin
				load_busy <= 1'b1;
				bus.arvalid <= 1'b1;
			end
			if (bus.arvalid && bus.arready) begin
				bus.arvalid <= 1'b0;
				bus.rready <= 1'b1;
			end
			if (bus.rvalid && bus.rready) begin
				bus.rready <= 1'b0;
				load_done <= 1'b1;
			end
			// busy drops after the done cycle
			if (load_done)
				load_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			bus.araddr <= load_addr;
		if (bus.rvalid && bus.rready)
			load_data <= bus.rdata;
	end

endmodule

//--- source/bus_arbiter.sv
////////////////////////////////////////
// Round-robin arbiter between fetch and load on one read bus.
// Only one transaction is outstanding; the grant is held from the
// first presented request through the data handshake.
////////////////////////////////////////
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         mem_arready,
	input  logic                         mem_rvalid,
	input  logic [fetch_pkg::data_w-1:0] mem_rdata,
	output logic [fetch_pkg::addr_w-1:0] mem_araddr,
	output logic                         mem_arvalid,
	output logic                         mem_rready,
	mem_rd_if.arbiter                    fetch_bus,
	mem_rd_if.arbiter                    load_bus
);

	logic busy;
	logic grant_load;
	logic last_load;
	logic pick_load;
	logic sel_load;

	// on a tie the side not served last wins
	assign pick_load = load_bus.arvalid & (~fetch_bus.arvalid | ~last_load);
	assign sel_load = busy ? grant_load : pick_load;

	assign mem_araddr = sel_load ? load_bus.araddr : fetch_bus.araddr;
	assign mem_arvalid = sel_load ? load_bus.arvalid : fetch_bus.arvalid;
	assign mem_rready = sel_load ? load_bus.rready : fetch_bus.rready;

	assign fetch_bus.arready = ~sel_load & mem_arready;
	assign fetch_bus.rvalid = ~sel_load & mem_rvalid;
	assign fetch_bus.rdata = sel_load ? '0 : mem_rdata;

	assign load_bus.arready = sel_load & mem_arready;
	assign load_bus.rvalid = sel_load & mem_rvalid;
	assign load_bus.rdata = sel_load ? mem_rdata : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			grant_load <= 1'b0;
			// fetch goes first after reset
			last_load <= 1'b1;
		end else begin
			if (!busy) begin
				if (mem_arvalid) begin
					busy <= 1'b1;
					grant_load <= sel_load;
				end
			end else if (mem_rvalid && mem_rready) begin
				busy <= 1'b0;
				last_load <= grant_load;
			end
		end
	end

endmodule

//--- source/fetch_subsystem.sv
////////////////////////////////////////
// Front end top: fetch and load share one read-only bus.
// reset_pc is the first fetch address after reset.
////////////////////////////////////////
`timescale 1ns/1ps

module fetch_subsystem #(
	parameter logic [fetch_pkg::addr_w-1:0] reset_pc = 32'h8000_0000
) (
	input  logic                         clk,
	input  logic                         reset,
	output logic                         inst_valid,
	input  logic                         inst_ready,
	output fetch_pkg::inst_word_t        inst,
	output logic [fetch_pkg::addr_w-1:0] inst_pc,
	input  logic                         redirect,
	input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
	input  logic                         exc,
	input  logic [fetch_pkg::addr_w-1:0] trap_vector,
	input  logic                         load_req,
	input  logic [fetch_pkg::addr_w-1:0] load_addr,
	output logic                         load_busy,
	output logic                         load_done,
	output logic [fetch_pkg::data_w-1:0] load_data,
	output logic [fetch_pkg::addr_w-1:0] mem_araddr,
	output logic                         mem_arvalid,
	input  logic                         mem_arready,
	input  logic                         mem_rvalid,
	output logic                         mem_rready,
	input  logic [fetch_pkg::data_w-1:0] mem_rdata
);

	mem_rd_if fetch_bus ();
	mem_rd_if load_bus ();

	fetch_unit #(
		.reset_pc(reset_pc)
	) fetch0 (
		.clk(clk),
		.reset(reset),
		.inst_ready(inst_ready),
		.redirect(redirect),
		.exc(exc),
		.redirect_pc(redirect_pc),
		.trap_vector(trap_vector),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc),
		.bus(fetch_bus.requester)
	);

	load_port load0 (
		.clk(clk),
		.reset(reset),
		.load_req(load_req),
		.load_addr(load_addr),
		.load_busy(load_busy),
		.load_done(load_done),
		.load_data(load_data),
		.bus(load_bus.requester)
	);

	bus_arbiter arb0 (
		.clk(clk),
		.reset(reset),
		.mem_arready(mem_arready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.mem_araddr(mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_rready(mem_rready),
		.fetch_bus(fetch_bus.arbiter),
		.load_bus(load_bus.arbiter)
	);

endmodule

//--- verif/tb_mem_model.sv
////////////////////////////////////////
// Read-only memory slave for the shared bus, one read at a time.
// The word for an address comes from the image lookup port, so the
// image itself lives in the testbench. arready and rvalid stall at
// random from a fixed seed.
////////////////////////////////////////
`timescale 1ns/1ps

module tb_mem_model (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [31:0] image_addr,
	input  logic [31:0] image_data
);

	integer      seed = 32'h55ee;
	logic [31:0] r;
	logic        busy = 1'b0;
	logic        go_a = 1'b0;
	logic        go_r = 1'b0;

	assign arready = ~busy & go_a;

	initial begin
		rvalid <= 1'b0;
		rdata <= '0;
	end

	always @(posedge clk) begin
		r = $random(seed);
		// roughly one cycle in four stalls each channel
		go_a <= r[0] | r[1];
		go_r <= r[2] | r[3];
		if (reset) begin
			busy <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				busy <= 1'b1;
				image_addr <= araddr;
			end
			if (busy && !rvalid && go_r) begin
				rvalid <= 1'b1;
				rdata <= image_data;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

endmodule

//--- verif/tb_fetch_subsystem.sv
////////////////////////////////////////
// Testbench for fetch_subsystem with random decode back-pressure,
// redirects, traps and loads, checked against a PC and load model.
// Outputs are sampled on the falling edge.
// Redirect and trap pulses are kept sparse so that the 2-bit epoch
// cannot wrap during one outstanding read.
////////////////////////////////////////
`timescale 1ns/1ps

module tb_fetch_subsystem;

	localparam logic [31:0] reset_pc = 32'h8000_0000;
	localparam int ops = 3000;
	localparam int cycle_ns = 20;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  inst_valid;
	logic                  inst_ready;
	fetch_pkg::inst_word_t inst;
	logic [31:0]           inst_pc;
	logic                  redirect;
	logic [31:0]           redirect_pc;
	logic                  exc;
	logic [31:0]           trap_vector;
	logic                  load_req;
	logic [31:0]           load_addr;
	logic                  load_busy;
	logic                  load_done;
	logic [31:0]           load_data;
	logic [31:0]           mem_araddr;
	logic                  mem_arvalid;
	logic                  mem_arready;
	logic                  mem_rvalid;
	logic                  mem_rready;
	logic [31:0]           mem_rdata;
	logic [31:0]           image_addr;
	logic [31:0]           image_data;

	integer      seed;
	logic [31:0] r;
	logic [31:0] exp_pc = reset_pc;
	logic [31:0] word;
	logic [31:0] load_q[$];
	logic [63:0] prev_held;
	logic        hold_prev = 1'b0;
	logic        reset_tail = 1'b1;
	int          checks = 0;
	int          errors = 0;
	int          n_taken = 0;

	always #10 clk = ~clk;

	fetch_subsystem #(.reset_pc(reset_pc)) dut0 (.*);

	tb_mem_model mem0 (
		.clk(clk),
		.reset(reset),
		.araddr(mem_araddr),
		.arvalid(mem_arvalid),
		.arready(mem_arready),
		.rvalid(mem_rvalid),
		.rready(mem_rready),
		.rdata(mem_rdata),
		.image_addr(image_addr),
		.image_data(image_data)
	);

	// fixed memory image hashed from the whole address
	function automatic logic [31:0] image_word(input logic [31:0] addr);
		logic [31:0] h;
		h = (addr ^ 32'h55ee_1234) * 32'h9e37_79b1;
		h = (h ^ (h >> 16)) * 32'h85eb_ca6b;
		h = h ^ (h >> 13);
		// about one word in eight is a jal
		if (h[9:7] == 3'd0)
			h[6:0] = 7'b1101111;
		return h;
	endfunction

	assign image_data = image_word(image_addr);

	function automatic logic [31:0] jal_offset(input logic [31:0] w);
		return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	always @(negedge clk) begin
		if (reset || reset_tail) begin
			check_value("reset_state", 64'd0,
				64'({inst_valid, mem_arvalid, mem_rready, load_busy, load_done}));
		end else begin
			if (hold_prev && inst_valid)
				check_value("hold", prev_held, {inst_pc, inst});
			if (inst_valid && inst_ready) begin
				word = image_word(inst_pc);
				check_value("fetch_pc", 64'(exp_pc), 64'(inst_pc));
				check_value("fetch_data", 64'(word), 64'(inst));
				n_taken++;
				if (word[6:0] == 7'b1101111)
					exp_pc = inst_pc + jal_offset(word);
				else
					exp_pc = inst_pc + 32'd4;
			end
			// trap entry wins over redirect
			if (exc)
				exp_pc = trap_vector;
			else if (redirect)
				exp_pc = redirect_pc;
			// busy spans every cycle with a load in flight
			check_value("load_busy", 64'(load_q.size() != 0), 64'(load_busy));
			if (load_done) begin
				assert (load_q.size() != 0) else begin
					errors++;
					$display("load_done pulsed with no load request pending");
				end
				if (load_q.size() != 0)
					check_value("load_data", 64'(image_word(load_q.pop_front())), 64'(load_data));
			end
			if (load_req)
				load_q.push_back(load_addr);
			hold_prev = inst_valid && !inst_ready && !redirect && !exc;
			prev_held = {inst_pc, inst};
		end
		reset_tail = reset;
	end

	initial begin
		seed = 32'h55ee;
		reset = 1'b1;
		inst_ready = 1'b0;
		redirect = 1'b0;
		redirect_pc = 32'd0;
		exc = 1'b0;
		trap_vector = $random(seed) & 32'hffff_fffc;
		load_req = 1'b0;
		load_addr = 32'd0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		while (n_taken < ops || load_q.size() != 0) begin
			@(posedge clk);
			#2;
			r = $random(seed);
			inst_ready = r[0] | r[1];
			exc = (r[14:8] == 7'd0);
			// half of the trap pulses land on a redirect
			redirect = (r[7:2] == 6'd0) || (exc && r[18]);
			load_req = (r[17:15] == 3'd0) && !load_busy && n_taken < ops;
			redirect_pc = $random(seed) & 32'hffff_fffc;
			load_addr = $random(seed) & 32'hffff_fffc;
		end
		$display("checks %0d, errors %0d, instructions taken %0d", checks, errors, n_taken);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(ops * 40 * cycle_ns);
		$display("timeout: %0d instructions taken, %0d loads unanswered", n_taken, load_q.size());
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sources.f
source/fetch_pkg.sv
source/mem_rd_if.sv
source/fetch_unit.sv
source/load_port.sv
source/bus_arbiter.sv
source/fetch_subsystem.sv
verif/tb_mem_model.sv
verif/tb_fetch_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_fetch_subsystem -f sources.f -o sim_fetch

out=$(./obj_dir/sim_fetch)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
	exit 0
else
	exit 1
fi
